//--- hw/disk_pkg.sv
package disk_pkg;

    // ========================================
    // Image geometry
    // ========================================

    // An image is 16 sectors of 8 words
    localparam int LBA_BITS      = 4;
    localparam int OFFSET_BITS   = 3;
    localparam int ADDR_BITS     = LBA_BITS + OFFSET_BITS;
    localparam int IMAGE_SECTORS = 1 << LBA_BITS;
    localparam int IMAGE_WORDS   = 1 << ADDR_BITS;

    // Sector count reported by the host when an image is mounted
    localparam int SIZE_BITS = 32;

    typedef logic [15:0] word_t;

    // The store indexes memory with the flat view and checks bounds with the split view
    typedef union packed {
        logic [ADDR_BITS-1:0] flat;
        struct packed {
            logic [LBA_BITS-1:0]    lba;
            logic [OFFSET_BITS-1:0] offset;
        } split;
    } disk_addr_t;

    // ========================================
    // Status LEDs
    // ========================================

    // Low bits carry one presence flag per disk
    localparam int LED_BITS  = 5;
    localparam int LED_READ  = 3;
    localparam int LED_WRITE = 4;

endpackage

//--- hw/disk_port_arbiter.sv
`timescale 1ns/10ps

module disk_port_arbiter #(
    parameter int NUM_DISKS = 3
) (
    input  logic                                          clk50m,
    input  logic                                          reset,

    input  logic [NUM_DISKS-1:0]                          dsk_cyc,
    input  logic [NUM_DISKS-1:0]                          dsk_stb,
    input  logic [NUM_DISKS-1:0]                          dsk_we,
    input  disk_pkg::disk_addr_t [NUM_DISKS-1:0]          dsk_adr,
    input  disk_pkg::word_t [NUM_DISKS-1:0]               dsk_dat_w,
    output logic [NUM_DISKS-1:0]                          dsk_ack,
    output logic [NUM_DISKS-1:0]                          dsk_err,

    output logic                                          st_cyc,
    output logic                                          st_stb,
    output logic                                          st_we,
    output disk_pkg::disk_addr_t                          st_adr,
    output disk_pkg::word_t                               st_dat_w,
    output logic [$clog2(NUM_DISKS)-1:0]                  st_disk,
    input  logic                                          st_ack,
    input  logic                                          st_err
);

    localparam int IDX_BITS = $clog2(NUM_DISKS);

    logic [IDX_BITS-1:0] gnt_idx;
    logic                gnt_valid;
    logic [IDX_BITS-1:0] pick_idx;

    // ========================================
    // Request selection
    // ========================================

    // Scan upwards so the highest pending index is the one left standing,
    // which matches the last-match-wins LBA mux of the board wrapper
    always_comb begin
        pick_idx = '0;
        for (int i = 0; i < NUM_DISKS; i++) begin
            if (dsk_cyc[i]) begin
                pick_idx = IDX_BITS'(i);
            end
        end
    end

    // A grant lives for the whole bus cycle of its master
    always_ff @(posedge clk50m) begin
        if (reset) begin
            gnt_valid <= 1'b0;
            gnt_idx   <= '0;
        end else if (!gnt_valid) begin
            if (|dsk_cyc) begin
                gnt_valid <= 1'b1;
                gnt_idx   <= pick_idx;
            end
        end else if (!dsk_cyc[gnt_idx]) begin
            // Master has finished, the next grant waits one cycle
            gnt_valid <= 1'b0;
        end
    end

    // ========================================
    // Store port mux
    // ========================================

    // Only the bus control lines are qualified by the grant
    always_comb begin
        st_cyc   = gnt_valid & dsk_cyc[gnt_idx];
        st_stb   = gnt_valid & dsk_stb[gnt_idx];
        st_we    = dsk_we[gnt_idx];
        st_adr   = dsk_adr[gnt_idx];
        st_dat_w = dsk_dat_w[gnt_idx];
        st_disk  = gnt_idx;
    end

    // Responses go back to the granted port alone
    always_comb begin
        dsk_ack = '0;
        dsk_err = '0;
        if (gnt_valid) begin
            dsk_ack[gnt_idx] = st_ack;
            dsk_err[gnt_idx] = st_err;
        end
    end

endmodule

//--- hw/disk_mount_tracker.sv
`timescale 1ns/10ps

module disk_mount_tracker #(
    parameter int NUM_DISKS = 3
) (
    input  logic                                          clk50m,
    input  logic                                          reset,

    input  logic [NUM_DISKS-1:0]                          img_mounted,
    input  logic [disk_pkg::SIZE_BITS-1:0]                img_size,

    input  logic                                          st_stb,
    input  logic                                          st_we,
    input  logic                                          st_ack,

    output logic [NUM_DISKS-1:0]                          present,
    output logic [NUM_DISKS-1:0][disk_pkg::LBA_BITS:0]    sector_count,
    output logic [disk_pkg::LED_BITS-1:0]                 leds
);

    localparam int CNT_BITS = disk_pkg::LBA_BITS + 1;
    localparam logic [disk_pkg::SIZE_BITS-1:0] MAX_SECTORS = disk_pkg::IMAGE_SECTORS;

    logic [CNT_BITS-1:0] size_sat;
    logic                rd_busy;
    logic                wr_busy;

    // Host may hand over an image bigger than the store can hold
    always_comb begin
        if (img_size > MAX_SECTORS) begin
            size_sat = MAX_SECTORS[CNT_BITS-1:0];
        end else begin
            size_sat = img_size[CNT_BITS-1:0];
        end
    end

    // A zero size means the image was ejected
    always_ff @(posedge clk50m) begin
        if (reset) begin
            present      <= '0;
            sector_count <= '0;
        end else begin
            for (int i = 0; i < NUM_DISKS; i++) begin
                if (img_mounted[i]) begin
                    present[i]      <= |img_size;
                    sector_count[i] <= size_sat;
                end
            end
        end
    end

    // Activity is held from the strobed access until the store answers
    always_ff @(posedge clk50m) begin
        if (reset) begin
            rd_busy <= 1'b0;
            wr_busy <= 1'b0;
        end else begin
            rd_busy <= st_stb & ~st_we & ~st_ack;
            wr_busy <= st_stb & st_we & ~st_ack;
        end
    end

    always_comb begin
        leds                      = '0;
        leds[NUM_DISKS-1:0]       = present;
        leds[disk_pkg::LED_READ]  = rd_busy;
        leds[disk_pkg::LED_WRITE] = wr_busy;
    end

endmodule

//--- hw/sector_image_store.sv
`timescale 1ns/10ps

module sector_image_store #(
    parameter int NUM_DISKS = 3
) (
    input  logic                                          clk50m,
    input  logic                                          reset,

    input  logic                                          st_cyc,
    input  logic                                          st_stb,
    input  logic                                          st_we,
    input  disk_pkg::disk_addr_t                          st_adr,
    input  disk_pkg::word_t                               st_dat_w,
    input  logic [$clog2(NUM_DISKS)-1:0]                  st_disk,

    input  logic [NUM_DISKS-1:0]                          present,
    input  logic [NUM_DISKS-1:0][disk_pkg::LBA_BITS:0]    sector_count,

    output logic                                          st_ack,
    output logic                                          st_err,
    output disk_pkg::word_t                               st_dat_r
);

    // All images side by side, one row per disk
    disk_pkg::word_t mem [NUM_DISKS][disk_pkg::IMAGE_WORDS];

    logic disk_ok;
    logic in_range;
    logic start;
    logic accept;

    // ========================================
    // Access check
    // ========================================

    // Sector number must fall inside the image that was mounted
    always_comb begin
        disk_ok  = st_disk < NUM_DISKS;
        in_range = 1'b0;
        if (disk_ok) begin
            in_range = present[st_disk] &&
                       ({1'b0, st_adr.split.lba} < sector_count[st_disk]);
        end
    end

    // The master keeps its strobe up during the response cycle,
    // so a pending answer blocks a second start
    assign start  = st_cyc & st_stb & ~st_ack & ~st_err;
    assign accept = start & in_range;

    // ========================================
    // Response and memory
    // ========================================

    always_ff @(posedge clk50m) begin
        if (reset) begin
            st_ack <= 1'b0;
            st_err <= 1'b0;
        end else begin
            st_ack <= accept;
            st_err <= start & ~in_range;
        end
    end

    // A rejected access leaves the image untouched
    always_ff @(posedge clk50m) begin
        if (accept) begin
            if (st_we) begin
                mem[st_disk][st_adr.flat] <= st_dat_w;
            end else begin
                st_dat_r <= mem[st_disk][st_adr.flat];
            end
        end
    end

endmodule

//--- hw/disk_image_top.sv
`timescale 1ns/10ps

module disk_image_top #(
    parameter int NUM_DISKS = 3
) (
    input  logic                                          clk50m,
    input  logic                                          reset,

    // Controller ports, packed by disk index
    input  logic [NUM_DISKS-1:0]                          dsk_cyc,
    input  logic [NUM_DISKS-1:0]                          dsk_stb,
    input  logic [NUM_DISKS-1:0]                          dsk_we,
    input  disk_pkg::disk_addr_t [NUM_DISKS-1:0]          dsk_adr,
    input  disk_pkg::word_t [NUM_DISKS-1:0]               dsk_dat_w,
    output logic [NUM_DISKS-1:0]                          dsk_ack,
    output logic [NUM_DISKS-1:0]                          dsk_err,
    output disk_pkg::word_t                               dsk_dat_r,

    // Host side mount events
    input  logic [NUM_DISKS-1:0]                          img_mounted,
    input  logic [disk_pkg::SIZE_BITS-1:0]                img_size,

    output logic [disk_pkg::LED_BITS-1:0]                 leds
);

    // ========================================
    // Shared store port
    // ========================================

    logic                                       st_cyc;
    logic                                       st_stb;
    logic                                       st_we;
    disk_pkg::disk_addr_t                       st_adr;
    disk_pkg::word_t                            st_dat_w;
    logic [$clog2(NUM_DISKS)-1:0]               st_disk;
    logic                                       st_ack;
    logic                                       st_err;

    logic [NUM_DISKS-1:0]                       present;
    logic [NUM_DISKS-1:0][disk_pkg::LBA_BITS:0] sector_count;

    disk_port_arbiter #(
        .NUM_DISKS (NUM_DISKS)
    ) u_arbiter (
        .clk50m    (clk50m),
        .reset     (reset),
        .dsk_cyc   (dsk_cyc),
        .dsk_stb   (dsk_stb),
        .dsk_we    (dsk_we),
        .dsk_adr   (dsk_adr),
        .dsk_dat_w (dsk_dat_w),
        .dsk_ack   (dsk_ack),
        .dsk_err   (dsk_err),
        .st_cyc    (st_cyc),
        .st_stb    (st_stb),
        .st_we     (st_we),
        .st_adr    (st_adr),
        .st_dat_w  (st_dat_w),
        .st_disk   (st_disk),
        .st_ack    (st_ack),
        .st_err    (st_err)
    );

    disk_mount_tracker #(
        .NUM_DISKS (NUM_DISKS)
    ) u_mount (
        .clk50m       (clk50m),
        .reset        (reset),
        .img_mounted  (img_mounted),
        .img_size     (img_size),
        .st_stb       (st_stb),
        .st_we        (st_we),
        .st_ack       (st_ack),
        .present      (present),
        .sector_count (sector_count),
        .leds         (leds)
    );

    // Read data is shared by all ports and qualified by each port's ack
    sector_image_store #(
        .NUM_DISKS (NUM_DISKS)
    ) u_store (
        .clk50m       (clk50m),
        .reset        (reset),
        .st_cyc       (st_cyc),
        .st_stb       (st_stb),
        .st_we        (st_we),
        .st_adr       (st_adr),
        .st_dat_w     (st_dat_w),
        .st_disk      (st_disk),
        .present      (present),
        .sector_count (sector_count),
        .st_ack       (st_ack),
        .st_err       (st_err),
        .st_dat_r     (dsk_dat_r)
    );

endmodule

//--- test/tb_disk_model.svh
`ifndef TB_DISK_MODEL_SVH
`define TB_DISK_MODEL_SVH

// One finished bus cycle as the controller saw it
typedef struct packed {
    int                            port;
    bit                            we;
    disk_pkg::disk_addr_t          adr;
    disk_pkg::word_t               wdat;
    bit                            got_err;
    disk_pkg::word_t               rdat;
    logic [disk_pkg::LED_BITS-1:0] leds;
    int                            cycles;
    bit                            uncontested;
} access_rec_t;

access_rec_t done_q[$];
int          finish_order[$];
int          pushed_count;
int          checked_count;

// Reference images and mount state
disk_pkg::word_t ref_mem [NUM_DISKS][disk_pkg::IMAGE_WORDS];
bit              ref_present [NUM_DISKS];
int              ref_count [NUM_DISKS];

// Err is expected for an absent disk or for a sector past the mounted size
function automatic bit expect_access(input int port, input disk_pkg::disk_addr_t adr,
                                     output disk_pkg::word_t rdat);
    int sector;
    sector = int'(adr.flat) >> disk_pkg::OFFSET_BITS;
    rdat   = ref_mem[port][adr.flat];
    return !(ref_present[port] && sector < ref_count[port]);
endfunction

// Called one step after a rising edge, returns at the same phase
task automatic mount_image(input int port, input int unsigned size);
    img_mounted[port] = 1'b1;
    img_size          = size;
    @(posedge clk50m);
    #1;
    img_mounted       = '0;
    ref_present[port] = (size != 0);
    ref_count[port]   = (size > disk_pkg::IMAGE_SECTORS) ? disk_pkg::IMAGE_SECTORS : int'(size);
endtask

task automatic bus_cycle(input int port, input bit we, input disk_pkg::disk_addr_t adr,
                         input disk_pkg::word_t wdat, input bit uncontested);
    access_rec_t rec;
    rec             = '0;
    rec.port        = port;
    rec.we          = we;
    rec.adr         = adr;
    rec.wdat        = wdat;
    rec.uncontested = uncontested;
    dsk_cyc[port]   = 1'b1;
    dsk_stb[port]   = 1'b1;
    dsk_we[port]    = we;
    dsk_adr[port]   = adr;
    dsk_dat_w[port] = wdat;
    // Responses are sampled mid-cycle where they are stable
    do begin
        @(posedge clk50m);
        rec.cycles++;
        @(negedge clk50m);
    end while (!dsk_ack[port] && !dsk_err[port]);
    rec.got_err = dsk_err[port];
    rec.rdat    = dsk_dat_r;
    rec.leds    = leds;
    done_q.push_back(rec);
    finish_order.push_back(port);
    pushed_count++;
    @(posedge clk50m);
    #1;
    dsk_cyc[port] = 1'b0;
    dsk_stb[port] = 1'b0;
    @(posedge clk50m);
    #1;
endtask

task automatic write_word(input int port, input disk_pkg::disk_addr_t adr,
                          input disk_pkg::word_t data);
    bus_cycle(port, 1'b1, adr, data, 1'b1);
endtask

task automatic read_word(input int port, input disk_pkg::disk_addr_t adr);
    bus_cycle(port, 1'b0, adr, '0, 1'b1);
endtask

`endif

//--- test/tb_disk_image.sv
`timescale 1ns/10ps

module tb_disk_image;

    localparam int NUM_DISKS    = 3;
    localparam int RANDOM_WORDS = 6;
    // Random and same-address phases, then the error and contested phases
    localparam int ACCESS_COUNT = NUM_DISKS * 2 * RANDOM_WORDS + 2 * NUM_DISKS + 7 + 4;
    localparam int WATCHDOG_CYCLES = ACCESS_COUNT * 20 + 200;

    logic                                 clk50m;
    logic                                 reset;
    logic [NUM_DISKS-1:0]                 dsk_cyc;
    logic [NUM_DISKS-1:0]                 dsk_stb;
    logic [NUM_DISKS-1:0]                 dsk_we;
    disk_pkg::disk_addr_t [NUM_DISKS-1:0] dsk_adr;
    disk_pkg::word_t [NUM_DISKS-1:0]      dsk_dat_w;
    logic [NUM_DISKS-1:0]                 dsk_ack;
    logic [NUM_DISKS-1:0]                 dsk_err;
    disk_pkg::word_t                      dsk_dat_r;
    logic [NUM_DISKS-1:0]                 img_mounted;
    logic [disk_pkg::SIZE_BITS-1:0]       img_size;
    logic [disk_pkg::LED_BITS-1:0]        leds;

    `include "tb_disk_model.svh"

    disk_image_top #(
        .NUM_DISKS (NUM_DISKS)
    ) u_dut (
        .clk50m      (clk50m),
        .reset       (reset),
        .dsk_cyc     (dsk_cyc),
        .dsk_stb     (dsk_stb),
        .dsk_we      (dsk_we),
        .dsk_adr     (dsk_adr),
        .dsk_dat_w   (dsk_dat_w),
        .dsk_ack     (dsk_ack),
        .dsk_err     (dsk_err),
        .dsk_dat_r   (dsk_dat_r),
        .img_mounted (img_mounted),
        .img_size    (img_size),
        .leds        (leds)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    function automatic disk_pkg::disk_addr_t random_address(input int port);
        disk_pkg::disk_addr_t adr;
        logic [31:0]          lba;
        logic [31:0]          offset;
        lba              = $urandom_range(ref_count[port] - 1, 0);
        offset           = $urandom;
        adr.split.lba    = lba[disk_pkg::LBA_BITS-1:0];
        adr.split.offset = offset[disk_pkg::OFFSET_BITS-1:0];
        return adr;
    endfunction

    // Presence bits must match the model and both activity bits must be idle
    task automatic check_leds(input logic [NUM_DISKS-1:0] exp_present);
        @(negedge clk50m);
        assert (leds[NUM_DISKS-1:0] == exp_present)
            else fail_run($sformatf("ERR leds[2:0]: got %h expected %h",
                                    leds[NUM_DISKS-1:0], exp_present));
        assert (leds[disk_pkg::LED_WRITE:disk_pkg::LED_READ] == 2'b00)
            else fail_run($sformatf("ERR leds[4:3]: got %h expected 0 when idle",
                                    leds[disk_pkg::LED_WRITE:disk_pkg::LED_READ]));
        @(posedge clk50m);
        #1;
    endtask

    initial begin
        clk50m = 1'b0;
        forever #10 clk50m = ~clk50m;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk50m);
        fail_run("Timeout: the tests did not finish in time");
    end

    // ========================================
    // Compare process
    // ========================================

    initial begin : compare
        access_rec_t     rec;
        bit              exp_err;
        disk_pkg::word_t exp_data;
        logic [1:0]      exp_act;
        forever begin
            wait (pushed_count != checked_count);
            rec     = done_q.pop_front();
            exp_err = expect_access(rec.port, rec.adr, exp_data);
            exp_act = rec.we ? 2'b10 : 2'b01;
            assert (rec.got_err == exp_err)
                else fail_run($sformatf("ERR dsk_err[%0d] at %h: got %h expected %h",
                                        rec.port, rec.adr, rec.got_err, exp_err));
            if (rec.uncontested) begin
                assert (rec.cycles == 2)
                    else fail_run($sformatf("Port %0d answered after %0d cycles instead of 2",
                                            rec.port, rec.cycles));
            end
            if (!exp_err && !rec.we) begin
                assert (rec.rdat == exp_data)
                    else fail_run($sformatf("ERR dsk_dat_r port %0d at %h: got %h expected %h",
                                            rec.port, rec.adr, rec.rdat, exp_data));
            end
            assert (rec.leds[disk_pkg::LED_WRITE:disk_pkg::LED_READ] == exp_act)
                else fail_run($sformatf("ERR leds[4:3] port %0d: got %h expected %h", rec.port,
                                        rec.leds[disk_pkg::LED_WRITE:disk_pkg::LED_READ],
                                        exp_act));
            if (!exp_err && rec.we) begin
                ref_mem[rec.port][rec.adr.flat] = rec.wdat;
            end
            checked_count++;
        end
    end

    // ========================================
    // Stimulus
    // ========================================

    initial begin : stimulus
        disk_pkg::disk_addr_t adr;
        disk_pkg::disk_addr_t adr_b;
        disk_pkg::disk_addr_t adr_log [NUM_DISKS][RANDOM_WORDS];
        disk_pkg::word_t      data;
        void'($urandom(32'h1ff3_aaaa));
        reset       = 1'b1;
        dsk_cyc     = '0;
        dsk_stb     = '0;
        dsk_we      = '0;
        dsk_adr     = '0;
        dsk_dat_w   = '0;
        img_mounted = '0;
        img_size    = '0;
        repeat (3) @(posedge clk50m);
        #1;
        reset = 1'b0;

        @(negedge clk50m);
        assert (leds == '0) else fail_run($sformatf("ERR leds: got %h expected 0", leds));
        assert (dsk_ack == '0) else fail_run($sformatf("ERR dsk_ack: got %h expected 0", dsk_ack));
        assert (dsk_err == '0) else fail_run($sformatf("ERR dsk_err: got %h expected 0", dsk_err));
        @(posedge clk50m);
        #1;
        // Disk 2 reports more sectors than an image holds
        mount_image(0, 16);
        mount_image(1, 10);
        mount_image(2, 40);
        check_leds(3'b111);

        for (int d = 0; d < NUM_DISKS; d++) begin
            for (int n = 0; n < RANDOM_WORDS; n++) begin
                adr_log[d][n] = random_address(d);
                write_word(d, adr_log[d][n], disk_pkg::word_t'($urandom));
            end
            for (int n = 0; n < RANDOM_WORDS; n++) begin
                read_word(d, adr_log[d][n]);
            end
        end
        // One address, a different word on every disk
        adr  = random_address(1);
        data = disk_pkg::word_t'($urandom);
        for (int d = 0; d < NUM_DISKS; d++) begin
            write_word(d, adr, data ^ disk_pkg::word_t'(16'h1111 * d));
        end
        for (int d = 0; d < NUM_DISKS; d++) begin
            read_word(d, adr);
        end
        check_leds(3'b111);

        // Sector 12 is written while disk 1 is large, then rejected once it shrinks
        adr.split.lba    = 4'd12;
        adr.split.offset = 3'd5;
        mount_image(1, 16);
        write_word(1, adr, data);
        mount_image(1, 10);
        write_word(1, adr, ~data);
        mount_image(1, 16);
        read_word(1, adr);
        // Ejected disk 0 rejects everything and keeps its image
        adr = random_address(0);
        write_word(0, adr, data);
        mount_image(0, 0);
        check_leds(3'b110);
        write_word(0, adr, ~data);
        read_word(0, adr);
        mount_image(0, 16);
        read_word(0, adr);
        check_leds(3'b111);

        adr   = random_address(0);
        adr_b = random_address(2);
        write_word(0, adr, disk_pkg::word_t'($urandom));
        write_word(2, adr_b, disk_pkg::word_t'($urandom));
        finish_order.delete();
        fork
            bus_cycle(0, 1'b0, adr, '0, 1'b0);
            bus_cycle(2, 1'b0, adr_b, '0, 1'b0);
        join
        assert (finish_order.size() == 2 && finish_order[0] == 2 && finish_order[1] == 0)
            else fail_run("Disk 2 did not finish ahead of disk 0 on a tied request");
        check_leds(3'b111);

        wait (checked_count == pushed_count);
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- compile.f
+incdir+test
hw/disk_pkg.sv
hw/disk_port_arbiter.sv
hw/disk_mount_tracker.sv
hw/sector_image_store.sv
hw/disk_image_top.sv
test/tb_disk_image.sv

//--- run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_disk_image -f compile.f -o tb_disk_image
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_disk_image 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if echo "$out" | grep -qx "Done: no errors"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
